// File: rtl/udp_pipe_params.svh
// UDP pipeline adapter widths and protocol constants
`ifndef UDP_PIPE_PARAMS_SVH
`define UDP_PIPE_PARAMS_SVH

// Payload stream
`define UDP_DATA_W 64
`define UDP_KEEP_W 8

// Packed header word carried by the onboard pipeline
`define UDP_HDR_W 112

// Address and port fields
`define UDP_IP_W 32
`define UDP_PORT_W 16

// UDP header size in bytes, removed on receive and restored on transmit
`define UDP_HDR_BYTES 8

// Upper half of every reply address, 192.168
`define UDP_REPLY_PREFIX {8'd192, 8'd168}

// Board LEDs
`define UDP_LED_W 8

`endif

// File: rtl/udp_pipe_pkg.sv
// Shared types for the UDP pipeline adapter
`include "udp_pipe_params.svh"

package udp_pipe_pkg;

    // Receive frame tracking
    typedef enum logic [0:0] {
        FRAME_IDLE = 1'b0,
        FRAME_BODY = 1'b1
    } frame_state_t;

    // IPv4 address
    typedef logic [`UDP_IP_W-1:0] ip_addr_t;

    // UDP port or length
    typedef logic [`UDP_PORT_W-1:0] udp_port_t;

    // Header word as seen by the pipeline.
    // From the top: length, dest port, source port, dest IP,
    // then source IP low half with the source port folded in.
    typedef logic [`UDP_HDR_W-1:0] hdr_word_t;

endpackage

// File: rtl/axis_skid_buffer.sv
// AXI-Stream register slice with a skid entry for the 64-bit UDP payload
`timescale 1ns/10ps
`include "udp_pipe_params.svh"

module axis_skid_buffer (
    input  logic                   clk,
    input  logic                   reset,

    // Upstream
    input  logic [`UDP_DATA_W-1:0] s_tdata,
    input  logic [`UDP_KEEP_W-1:0] s_tkeep,
    input  logic                   s_tvalid,
    output logic                   s_tready,
    input  logic                   s_tlast,
    input  logic                   s_tuser,

    // Downstream
    output logic [`UDP_DATA_W-1:0] m_tdata,
    output logic [`UDP_KEEP_W-1:0] m_tkeep,
    output logic                   m_tvalid,
    input  logic                   m_tready,
    output logic                   m_tlast,
    output logic                   m_tuser
);

    // Beat caught while the output is stalled
    logic [`UDP_DATA_W-1:0] skid_tdata;
    logic [`UDP_KEEP_W-1:0] skid_tkeep;
    logic                   skid_tlast;
    logic                   skid_tuser;
    logic                   skid_valid;

    logic s_xfer;
    logic m_free;

    // Ready is a flop output, low only with both entries occupied
    assign s_tready = ~skid_valid;
    assign s_xfer   = s_tvalid & s_tready;

    // Output register can take a new beat this cycle
    assign m_free = ~m_tvalid | m_tready;

    always_ff @(posedge clk) begin
        if (reset) begin
            m_tvalid   <= 1'b0;
            skid_valid <= 1'b0;
        end else if (m_free) begin
            m_tvalid   <= skid_valid | s_xfer;
            skid_valid <= 1'b0;
        end else if (s_xfer) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        // Skid entry is older, so it drains first
        if (m_free) begin
            if (skid_valid) begin
                {m_tdata, m_tkeep, m_tlast, m_tuser} <=
                    {skid_tdata, skid_tkeep, skid_tlast, skid_tuser};
            end else begin
                {m_tdata, m_tkeep, m_tlast, m_tuser} <= {s_tdata, s_tkeep, s_tlast, s_tuser};
            end
        end
        if (!m_free && s_xfer) begin
            {skid_tdata, skid_tkeep, skid_tlast, skid_tuser} <=
                {s_tdata, s_tkeep, s_tlast, s_tuser};
        end
    end

    // A presented beat must stay until the consumer takes it
    a_valid_held: assert property (@(posedge clk) disable iff (reset)
        (m_tvalid && !m_tready) |=> m_tvalid);

endmodule

// File: rtl/udp_rx_hdr_pack.sv
// Receive UDP header packer into the 112-bit pipeline word
`timescale 1ns/10ps
`include "udp_pipe_params.svh"

module udp_rx_hdr_pack (
    input  logic                   clk,
    input  logic                   reset,

    // Header from the UDP/IP stack
    input  logic                   rx_udp_hdr_valid,
    output logic                   rx_udp_hdr_ready,
    input  udp_pipe_pkg::ip_addr_t  rx_udp_ip_source_ip,
    input  udp_pipe_pkg::ip_addr_t  rx_udp_ip_dest_ip,
    input  udp_pipe_pkg::udp_port_t rx_udp_source_port,
    input  udp_pipe_pkg::udp_port_t rx_udp_dest_port,
    input  udp_pipe_pkg::udp_port_t rx_udp_length,

    // Packed word to the pipeline
    output udp_pipe_pkg::hdr_word_t m_udp_hdr_data,
    output logic                   m_udp_hdr_valid,
    input  logic                   m_udp_hdr_ready
);

    import udp_pipe_pkg::*;

    hdr_word_t packed_word;
    hdr_word_t skid_data;
    logic      skid_valid;
    logic      in_xfer;
    logic      out_free;

    // Length becomes payload-only; the sender's port rides in the
    // low half of the source slot so a reply can find its way back
    assign packed_word = {
        rx_udp_length - udp_port_t'(`UDP_HDR_BYTES),
        rx_udp_dest_port,
        rx_udp_source_port,
        rx_udp_ip_dest_ip,
        rx_udp_ip_source_ip[`UDP_PORT_W-1:0],
        rx_udp_source_port
    };

    assign rx_udp_hdr_ready = ~skid_valid;
    assign in_xfer          = rx_udp_hdr_valid & rx_udp_hdr_ready;
    assign out_free         = ~m_udp_hdr_valid | m_udp_hdr_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            m_udp_hdr_valid <= 1'b0;
            skid_valid      <= 1'b0;
        end else if (out_free) begin
            m_udp_hdr_valid <= skid_valid | in_xfer;
            skid_valid      <= 1'b0;
        end else if (in_xfer) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            m_udp_hdr_data <= skid_valid ? skid_data : packed_word;
        end
        if (!out_free && in_xfer) begin
            skid_data <= packed_word;
        end
    end

    // Runt lengths would wrap on the subtraction
    a_len_min: assert property (@(posedge clk) disable iff (reset)
        in_xfer |-> (rx_udp_length >= udp_port_t'(`UDP_HDR_BYTES)));

endmodule

// File: rtl/udp_tx_hdr_unpack.sv
// Transmit header unpacker with reply address and length rewrite
`timescale 1ns/10ps
`include "udp_pipe_params.svh"

module udp_tx_hdr_unpack (
    input  logic                   clk,
    input  logic                   reset,

    // Packed word from the pipeline
    input  udp_pipe_pkg::hdr_word_t s_udp_hdr_data,
    input  logic                   s_udp_hdr_valid,
    output logic                   s_udp_hdr_ready,

    // Reply header to the UDP/IP stack
    output logic                   tx_udp_hdr_valid,
    input  logic                   tx_udp_hdr_ready,
    output udp_pipe_pkg::ip_addr_t  tx_udp_ip_dest_ip,
    output udp_pipe_pkg::udp_port_t tx_udp_dest_port,
    output udp_pipe_pkg::udp_port_t tx_udp_length
);

    import udp_pipe_pkg::*;

    ip_addr_t  reply_ip;
    udp_port_t reply_port;
    udp_port_t reply_len;

    ip_addr_t  skid_ip;
    udp_port_t skid_port;
    udp_port_t skid_len;
    logic      skid_valid;

    logic in_xfer;
    logic out_free;

    // Low slot holds the sender's address low half over its port
    assign reply_ip   = {`UDP_REPLY_PREFIX, s_udp_hdr_data[`UDP_IP_W-1 -: `UDP_PORT_W]};
    assign reply_port = s_udp_hdr_data[`UDP_PORT_W-1:0];
    assign reply_len  = s_udp_hdr_data[`UDP_HDR_W-1 -: `UDP_PORT_W]
                      + udp_port_t'(`UDP_HDR_BYTES);

    assign s_udp_hdr_ready = ~skid_valid;
    assign in_xfer         = s_udp_hdr_valid & s_udp_hdr_ready;
    assign out_free        = ~tx_udp_hdr_valid | tx_udp_hdr_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_udp_hdr_valid <= 1'b0;
            skid_valid       <= 1'b0;
        end else if (out_free) begin
            tx_udp_hdr_valid <= skid_valid | in_xfer;
            skid_valid       <= 1'b0;
        end else if (in_xfer) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                {tx_udp_ip_dest_ip, tx_udp_dest_port, tx_udp_length} <=
                    {skid_ip, skid_port, skid_len};
            end else begin
                {tx_udp_ip_dest_ip, tx_udp_dest_port, tx_udp_length} <=
                    {reply_ip, reply_port, reply_len};
            end
        end
        if (!out_free && in_xfer) begin
            {skid_ip, skid_port, skid_len} <= {reply_ip, reply_port, reply_len};
        end
    end

    // Stack may sample the fields late, so a stalled header must not move
    a_stall_stable: assert property (@(posedge clk) disable iff (reset)
        (tx_udp_hdr_valid && !tx_udp_hdr_ready) |=>
            (tx_udp_hdr_valid && $stable({tx_udp_ip_dest_ip, tx_udp_dest_port, tx_udp_length})));

endmodule

// File: rtl/udp_rx_frame_tracker.sv
// Receive frame tracker showing each frame's first payload byte on the LEDs
`timescale 1ns/10ps
`include "udp_pipe_params.svh"

module udp_rx_frame_tracker (
    input  logic                  clk,
    input  logic                  reset,

    // Handshake observed at the receive payload output
    input  logic                  beat_valid,
    input  logic                  beat_ready,
    input  logic                  beat_last,
    input  logic [`UDP_LED_W-1:0] beat_first_byte,

    output logic [`UDP_LED_W-1:0] led
);

    import udp_pipe_pkg::*;

    frame_state_t state;
    logic         beat_xfer;

    assign beat_xfer = beat_valid & beat_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FRAME_IDLE;
            led   <= '0;
        end else if (beat_xfer) begin
            case (state)
                FRAME_IDLE: begin
                    // Single-beat frames stay idle
                    led <= beat_first_byte;
                    if (!beat_last) begin
                        state <= FRAME_BODY;
                    end
                end
                FRAME_BODY: begin
                    if (beat_last) begin
                        state <= FRAME_IDLE;
                    end
                end
                default: state <= FRAME_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/udp_pipe_top.sv
// UDP pipeline adapter top between the onboard pipeline and the UDP/IP stack
`timescale 1ns/10ps
`include "udp_pipe_params.svh"

module udp_pipe_top (
    input  logic                    clk,
    input  logic                    reset,
    output logic [`UDP_LED_W-1:0]   led,

    // Receive header from the stack
    input  logic                    rx_udp_hdr_valid,
    output logic                    rx_udp_hdr_ready,
    input  udp_pipe_pkg::ip_addr_t  rx_udp_ip_source_ip,
    input  udp_pipe_pkg::ip_addr_t  rx_udp_ip_dest_ip,
    input  udp_pipe_pkg::udp_port_t rx_udp_source_port,
    input  udp_pipe_pkg::udp_port_t rx_udp_dest_port,
    input  udp_pipe_pkg::udp_port_t rx_udp_length,

    // Receive payload from the stack
    input  logic [`UDP_DATA_W-1:0]  rx_udp_payload_axis_tdata,
    input  logic [`UDP_KEEP_W-1:0]  rx_udp_payload_axis_tkeep,
    input  logic                    rx_udp_payload_axis_tvalid,
    output logic                    rx_udp_payload_axis_tready,
    input  logic                    rx_udp_payload_axis_tlast,
    input  logic                    rx_udp_payload_axis_tuser,

    // Pipeline output
    output udp_pipe_pkg::hdr_word_t m_udp_hdr_data,
    output logic                    m_udp_hdr_valid,
    input  logic                    m_udp_hdr_ready,
    output logic [`UDP_DATA_W-1:0]  m_udp_payload_axis_tdata,
    output logic [`UDP_KEEP_W-1:0]  m_udp_payload_axis_tkeep,
    output logic                    m_udp_payload_axis_tvalid,
    input  logic                    m_udp_payload_axis_tready,
    output logic                    m_udp_payload_axis_tlast,
    output logic                    m_udp_payload_axis_tuser,

    // Pipeline input
    input  udp_pipe_pkg::hdr_word_t s_udp_hdr_data,
    input  logic                    s_udp_hdr_valid,
    output logic                    s_udp_hdr_ready,
    input  logic [`UDP_DATA_W-1:0]  s_udp_payload_axis_tdata,
    input  logic [`UDP_KEEP_W-1:0]  s_udp_payload_axis_tkeep,
    input  logic                    s_udp_payload_axis_tvalid,
    output logic                    s_udp_payload_axis_tready,
    input  logic                    s_udp_payload_axis_tlast,
    input  logic                    s_udp_payload_axis_tuser,

    // Transmit header to the stack
    output logic                    tx_udp_hdr_valid,
    input  logic                    tx_udp_hdr_ready,
    output udp_pipe_pkg::ip_addr_t  tx_udp_ip_dest_ip,
    output udp_pipe_pkg::udp_port_t tx_udp_dest_port,
    output udp_pipe_pkg::udp_port_t tx_udp_length,

    // Transmit payload to the stack
    output logic [`UDP_DATA_W-1:0]  tx_udp_payload_axis_tdata,
    output logic [`UDP_KEEP_W-1:0]  tx_udp_payload_axis_tkeep,
    output logic                    tx_udp_payload_axis_tvalid,
    input  logic                    tx_udp_payload_axis_tready,
    output logic                    tx_udp_payload_axis_tlast,
    output logic                    tx_udp_payload_axis_tuser
);

    udp_rx_hdr_pack rx_hdr_pack_inst (
        .clk                 (clk),
        .reset               (reset),
        .rx_udp_hdr_valid    (rx_udp_hdr_valid),
        .rx_udp_hdr_ready    (rx_udp_hdr_ready),
        .rx_udp_ip_source_ip (rx_udp_ip_source_ip),
        .rx_udp_ip_dest_ip   (rx_udp_ip_dest_ip),
        .rx_udp_source_port  (rx_udp_source_port),
        .rx_udp_dest_port    (rx_udp_dest_port),
        .rx_udp_length       (rx_udp_length),
        .m_udp_hdr_data      (m_udp_hdr_data),
        .m_udp_hdr_valid     (m_udp_hdr_valid),
        .m_udp_hdr_ready     (m_udp_hdr_ready)
    );

    udp_tx_hdr_unpack tx_hdr_unpack_inst (
        .clk               (clk),
        .reset             (reset),
        .s_udp_hdr_data    (s_udp_hdr_data),
        .s_udp_hdr_valid   (s_udp_hdr_valid),
        .s_udp_hdr_ready   (s_udp_hdr_ready),
        .tx_udp_hdr_valid  (tx_udp_hdr_valid),
        .tx_udp_hdr_ready  (tx_udp_hdr_ready),
        .tx_udp_ip_dest_ip (tx_udp_ip_dest_ip),
        .tx_udp_dest_port  (tx_udp_dest_port),
        .tx_udp_length     (tx_udp_length)
    );

    // Stack to pipeline payload
    axis_skid_buffer rx_payload_inst (
        .clk      (clk),
        .reset    (reset),
        .s_tdata  (rx_udp_payload_axis_tdata),
        .s_tkeep  (rx_udp_payload_axis_tkeep),
        .s_tvalid (rx_udp_payload_axis_tvalid),
        .s_tready (rx_udp_payload_axis_tready),
        .s_tlast  (rx_udp_payload_axis_tlast),
        .s_tuser  (rx_udp_payload_axis_tuser),
        .m_tdata  (m_udp_payload_axis_tdata),
        .m_tkeep  (m_udp_payload_axis_tkeep),
        .m_tvalid (m_udp_payload_axis_tvalid),
        .m_tready (m_udp_payload_axis_tready),
        .m_tlast  (m_udp_payload_axis_tlast),
        .m_tuser  (m_udp_payload_axis_tuser)
    );

    // Pipeline to stack payload
    axis_skid_buffer tx_payload_inst (
        .clk      (clk),
        .reset    (reset),
        .s_tdata  (s_udp_payload_axis_tdata),
        .s_tkeep  (s_udp_payload_axis_tkeep),
        .s_tvalid (s_udp_payload_axis_tvalid),
        .s_tready (s_udp_payload_axis_tready),
        .s_tlast  (s_udp_payload_axis_tlast),
        .s_tuser  (s_udp_payload_axis_tuser),
        .m_tdata  (tx_udp_payload_axis_tdata),
        .m_tkeep  (tx_udp_payload_axis_tkeep),
        .m_tvalid (tx_udp_payload_axis_tvalid),
        .m_tready (tx_udp_payload_axis_tready),
        .m_tlast  (tx_udp_payload_axis_tlast),
        .m_tuser  (tx_udp_payload_axis_tuser)
    );

    // Watches the pipeline side of the receive payload
    udp_rx_frame_tracker rx_frame_tracker_inst (
        .clk             (clk),
        .reset           (reset),
        .beat_valid      (m_udp_payload_axis_tvalid),
        .beat_ready      (m_udp_payload_axis_tready),
        .beat_last       (m_udp_payload_axis_tlast),
        .beat_first_byte (m_udp_payload_axis_tdata[`UDP_LED_W-1:0]),
        .led             (led)
    );

endmodule

// File: sim/tb_udp_pipe.sv
// Self-checking testbench for the UDP pipeline adapter driven by golden vectors
`timescale 1ns/10ps
`include "udp_pipe_params.svh"

module tb_udp_pipe;

    import udp_pipe_pkg::*;

    localparam int BEAT_W = `UDP_DATA_W + `UDP_KEEP_W + 2;
    localparam int RXH_W  = 2 * `UDP_IP_W + 3 * `UDP_PORT_W;
    localparam int TXH_W  = `UDP_IP_W + 2 * `UDP_PORT_W;

    logic                  clk;
    logic                  reset;
    logic [`UDP_LED_W-1:0] led;

    // Stack side, receive
    logic                   rx_udp_hdr_valid, rx_udp_hdr_ready;
    ip_addr_t               rx_udp_ip_source_ip, rx_udp_ip_dest_ip;
    udp_port_t              rx_udp_source_port, rx_udp_dest_port, rx_udp_length;
    logic [`UDP_DATA_W-1:0] rx_udp_payload_axis_tdata;
    logic [`UDP_KEEP_W-1:0] rx_udp_payload_axis_tkeep;
    logic                   rx_udp_payload_axis_tvalid, rx_udp_payload_axis_tready;
    logic                   rx_udp_payload_axis_tlast, rx_udp_payload_axis_tuser;

    // Pipeline side, output
    hdr_word_t              m_udp_hdr_data;
    logic                   m_udp_hdr_valid, m_udp_hdr_ready;
    logic [`UDP_DATA_W-1:0] m_udp_payload_axis_tdata;
    logic [`UDP_KEEP_W-1:0] m_udp_payload_axis_tkeep;
    logic                   m_udp_payload_axis_tvalid, m_udp_payload_axis_tready;
    logic                   m_udp_payload_axis_tlast, m_udp_payload_axis_tuser;

    // Pipeline side, input
    hdr_word_t              s_udp_hdr_data;
    logic                   s_udp_hdr_valid, s_udp_hdr_ready;
    logic [`UDP_DATA_W-1:0] s_udp_payload_axis_tdata;
    logic [`UDP_KEEP_W-1:0] s_udp_payload_axis_tkeep;
    logic                   s_udp_payload_axis_tvalid, s_udp_payload_axis_tready;
    logic                   s_udp_payload_axis_tlast, s_udp_payload_axis_tuser;

    // Stack side, transmit
    logic                   tx_udp_hdr_valid, tx_udp_hdr_ready;
    ip_addr_t               tx_udp_ip_dest_ip;
    udp_port_t              tx_udp_dest_port, tx_udp_length;
    logic [`UDP_DATA_W-1:0] tx_udp_payload_axis_tdata;
    logic [`UDP_KEEP_W-1:0] tx_udp_payload_axis_tkeep;
    logic                   tx_udp_payload_axis_tvalid, tx_udp_payload_axis_tready;
    logic                   tx_udp_payload_axis_tlast, tx_udp_payload_axis_tuser;

    // Golden vectors, consumed in file order
    logic [RXH_W-1:0]      rxh_in[$];
    hdr_word_t             rxh_exp[$];
    hdr_word_t             txh_in[$];
    logic [TXH_W-1:0]      txh_exp[$];
    logic [BEAT_W-1:0]     rxp_beats[$];
    logic [BEAT_W-1:0]     txp_beats[$];
    logic [`UDP_LED_W-1:0] led_exp[$];

    int cycles = 0;
    int cycle_limit = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int total_checks = 0;

    udp_pipe_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: streams did not complete within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic random_ready();
        return ($urandom % 4) != 0;
    endfunction

    task automatic report_test(input string name, input int checked, input int errs);
        tests_run++;
        total_checks += checked;
        if (errs == 0 && checked > 0) begin
            $display("PASS  %s: %0d items checked", name, checked);
        end else begin
            tests_failed++;
            $display("FAIL  %s: %0d errors over %0d items", name, errs, checked);
        end
    endtask

    task automatic load_golden();
        int                     fd;
        int                     n;
        int                     lines;
        int                     bad;
        string                  rest;
        byte                    kind;
        logic                   dir;
        logic                   l;
        logic                   u;
        logic                   rx_open;
        logic [`UDP_DATA_W-1:0] d;
        logic [`UDP_KEEP_W-1:0] k;
        ip_addr_t               sip;
        ip_addr_t               dip;
        udp_port_t              sp;
        udp_port_t              dp;
        udp_port_t              len;
        hdr_word_t              w;
        rx_open = 1'b0;
        lines = 0;
        bad = 0;
        fd = $fopen("sim/udp_pipe_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file sim/udp_pipe_golden.txt");
            bad++;
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind == "#") begin
                    void'($fgets(rest, fd));
                end else if (kind == "R") begin
                    n = $fscanf(fd, " %h %h %h %h %h %h", sip, dip, sp, dp, len, w);
                    lines++;
                    if (n != 6) begin
                        $display("Golden file line %0d: receive header is incomplete", lines);
                        bad++;
                    end else begin
                        rxh_in.push_back({sip, dip, sp, dp, len});
                        rxh_exp.push_back(w);
                    end
                end else if (kind == "T") begin
                    n = $fscanf(fd, " %h %h %h %h", w, dip, dp, len);
                    lines++;
                    if (n != 4) begin
                        $display("Golden file line %0d: transmit word is incomplete", lines);
                        bad++;
                    end else begin
                        txh_in.push_back(w);
                        txh_exp.push_back({dip, dp, len});
                    end
                end else if (kind == "P") begin
                    n = $fscanf(fd, " %h %h %h %h %h", dir, d, k, l, u);
                    lines++;
                    if (n != 5) begin
                        $display("Golden file line %0d: payload beat is incomplete", lines);
                        bad++;
                    end else if (dir) begin
                        txp_beats.push_back({d, k, l, u});
                    end else begin
                        // Opening beat of a frame sets the LEDs
                        if (!rx_open) begin
                            led_exp.push_back(d[`UDP_LED_W-1:0]);
                        end
                        rx_open = !l;
                        rxp_beats.push_back({d, k, l, u});
                    end
                end else begin
                    $display("Golden file holds a line of unknown kind %c", kind);
                    void'($fgets(rest, fd));
                    bad++;
                end
            end
            $fclose(fd);
        end
        report_test("golden file", lines, bad);
    endtask

    task automatic check_reset_state();
        int errs;
        errs = 0;
        @(negedge clk);
        if ({m_udp_hdr_valid, tx_udp_hdr_valid, m_udp_payload_axis_tvalid,
             tx_udp_payload_axis_tvalid} !== 4'b0000) begin
            $display("[ERROR] %0t: an output valid is high after reset", $time);
            errs++;
        end
        if ({rx_udp_hdr_ready, s_udp_hdr_ready, rx_udp_payload_axis_tready,
             s_udp_payload_axis_tready} !== 4'b1111) begin
            $display("[ERROR] %0t: an input ready is low after reset", $time);
            errs++;
        end
        if (led !== '0) begin
            $display("[ERROR] %0t: led is %h after reset, expected 00", $time, led);
            errs++;
        end
        report_test("reset state", 3, errs);
    endtask

    task automatic run_rx_hdr();
        int sent;
        int got;
        int errs;
        sent = 0;
        got = 0;
        errs = 0;
        while (got < rxh_exp.size()) begin
            @(posedge clk);
            #1;
            rx_udp_hdr_valid = sent < rxh_in.size();
            if (sent < rxh_in.size()) begin
                {rx_udp_ip_source_ip, rx_udp_ip_dest_ip, rx_udp_source_port,
                 rx_udp_dest_port, rx_udp_length} = rxh_in[sent];
            end
            m_udp_hdr_ready = random_ready();
            @(negedge clk);
            if (rx_udp_hdr_valid && rx_udp_hdr_ready) begin
                sent++;
            end
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                if (m_udp_hdr_data !== rxh_exp[got]) begin
                    $display("[ERROR] %0t: rx header %0d packed %h, expected %h",
                             $time, got, m_udp_hdr_data, rxh_exp[got]);
                    errs++;
                end
                got++;
            end
        end
        report_test("rx header pack", got, errs);
    endtask

    task automatic run_tx_hdr();
        int sent;
        int got;
        int errs;
        sent = 0;
        got = 0;
        errs = 0;
        while (got < txh_exp.size()) begin
            @(posedge clk);
            #1;
            s_udp_hdr_valid = sent < txh_in.size();
            if (sent < txh_in.size()) begin
                s_udp_hdr_data = txh_in[sent];
            end
            tx_udp_hdr_ready = random_ready();
            @(negedge clk);
            if (s_udp_hdr_valid && s_udp_hdr_ready) begin
                sent++;
            end
            if (tx_udp_hdr_valid && tx_udp_hdr_ready) begin
                if ({tx_udp_ip_dest_ip, tx_udp_dest_port, tx_udp_length} !== txh_exp[got]) begin
                    $display("[ERROR] %0t: tx header %0d ip %h port %h len %h, expected %h",
                             $time, got, tx_udp_ip_dest_ip, tx_udp_dest_port,
                             tx_udp_length, txh_exp[got]);
                    errs++;
                end
                got++;
            end
        end
        report_test("tx header unpack", got, errs);
    endtask

    task automatic run_rx_payload();
        int                sent;
        int                got;
        int                frame;
        int                errs;
        int                led_errs;
        logic              led_due;
        logic [BEAT_W-1:0] seen;
        sent = 0;
        got = 0;
        frame = 0;
        errs = 0;
        led_errs = 0;
        led_due = 1'b0;
        // One extra cycle after the last beat for its frame's LED check
        while (got < rxp_beats.size() || led_due) begin
            @(posedge clk);
            #1;
            rx_udp_payload_axis_tvalid = sent < rxp_beats.size();
            if (sent < rxp_beats.size()) begin
                {rx_udp_payload_axis_tdata, rx_udp_payload_axis_tkeep,
                 rx_udp_payload_axis_tlast, rx_udp_payload_axis_tuser} = rxp_beats[sent];
            end
            m_udp_payload_axis_tready = random_ready();
            @(negedge clk);
            if (led_due) begin
                if (led !== led_exp[frame]) begin
                    $display("[ERROR] %0t: led after rx frame %0d is %h, expected %h",
                             $time, frame, led, led_exp[frame]);
                    led_errs++;
                end
                frame++;
                led_due = 1'b0;
            end
            if (rx_udp_payload_axis_tvalid && rx_udp_payload_axis_tready) begin
                sent++;
            end
            if (m_udp_payload_axis_tvalid && m_udp_payload_axis_tready) begin
                seen = {m_udp_payload_axis_tdata, m_udp_payload_axis_tkeep,
                        m_udp_payload_axis_tlast, m_udp_payload_axis_tuser};
                if (seen !== rxp_beats[got]) begin
                    $display("[ERROR] %0t: rx beat %0d got %h, expected %h",
                             $time, got, seen, rxp_beats[got]);
                    errs++;
                end
                led_due = m_udp_payload_axis_tlast;
                got++;
            end
        end
        report_test("rx payload stream", got, errs);
        report_test("led capture", frame, led_errs);
    endtask

    task automatic run_tx_payload();
        int                sent;
        int                got;
        int                errs;
        logic [BEAT_W-1:0] seen;
        sent = 0;
        got = 0;
        errs = 0;
        while (got < txp_beats.size()) begin
            @(posedge clk);
            #1;
            s_udp_payload_axis_tvalid = sent < txp_beats.size();
            if (sent < txp_beats.size()) begin
                {s_udp_payload_axis_tdata, s_udp_payload_axis_tkeep,
                 s_udp_payload_axis_tlast, s_udp_payload_axis_tuser} = txp_beats[sent];
            end
            tx_udp_payload_axis_tready = random_ready();
            @(negedge clk);
            if (s_udp_payload_axis_tvalid && s_udp_payload_axis_tready) begin
                sent++;
            end
            if (tx_udp_payload_axis_tvalid && tx_udp_payload_axis_tready) begin
                seen = {tx_udp_payload_axis_tdata, tx_udp_payload_axis_tkeep,
                        tx_udp_payload_axis_tlast, tx_udp_payload_axis_tuser};
                if (seen !== txp_beats[got]) begin
                    $display("[ERROR] %0t: tx beat %0d got %h, expected %h",
                             $time, got, seen, txp_beats[got]);
                    errs++;
                end
                got++;
            end
        end
        report_test("tx payload stream", got, errs);
    endtask

    // Anything still coming out now is a duplicate
    task automatic check_drained();
        int errs;
        errs = 0;
        @(posedge clk);
        #1;
        {rx_udp_hdr_valid, s_udp_hdr_valid} = '0;
        {rx_udp_payload_axis_tvalid, s_udp_payload_axis_tvalid} = '0;
        {m_udp_hdr_ready, tx_udp_hdr_ready} = '1;
        {m_udp_payload_axis_tready, tx_udp_payload_axis_tready} = '1;
        repeat (4) begin
            @(negedge clk);
            if ({m_udp_hdr_valid, tx_udp_hdr_valid, m_udp_payload_axis_tvalid,
                 tx_udp_payload_axis_tvalid} !== 4'b0000) begin
                $display("[ERROR] %0t: output valid after every item was taken", $time);
                errs++;
            end
        end
        report_test("no extra output", 1, errs);
    endtask

    initial begin
        void'($urandom(2842));
        reset = 1'b1;
        {rx_udp_hdr_valid, rx_udp_payload_axis_tvalid} = '0;
        {s_udp_hdr_valid, s_udp_payload_axis_tvalid} = '0;
        {m_udp_hdr_ready, m_udp_payload_axis_tready} = '0;
        {tx_udp_hdr_ready, tx_udp_payload_axis_tready} = '0;
        {rx_udp_ip_source_ip, rx_udp_ip_dest_ip} = '0;
        {rx_udp_source_port, rx_udp_dest_port, rx_udp_length} = '0;
        {rx_udp_payload_axis_tdata, rx_udp_payload_axis_tkeep} = '0;
        {rx_udp_payload_axis_tlast, rx_udp_payload_axis_tuser} = '0;
        s_udp_hdr_data = '0;
        {s_udp_payload_axis_tdata, s_udp_payload_axis_tkeep} = '0;
        {s_udp_payload_axis_tlast, s_udp_payload_axis_tuser} = '0;
        load_golden();
        cycle_limit = 10 * (rxh_in.size() + txh_in.size() + rxp_beats.size()
                      + txp_beats.size()) + 200;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_state();
        fork
            run_rx_hdr();
            run_tx_hdr();
            run_rx_payload();
            run_tx_payload();
        join
        check_drained();
        $display("Tests run %0d, failed %0d, items checked %0d",
                 tests_run, tests_failed, total_checks);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim/udp_pipe_golden.txt
# Columns, all hex
#   R src_ip dst_ip src_port dst_port length expected_packed_word
#   T packed_word expected_dst_ip expected_dst_port expected_length
#   P direction(0 rx, 1 tx) tdata tkeep tlast tuser
R c0a8010a c0a80114 d431 04d2 0020 001804d2d431c0a80114010ad431
R 0a000005 c0a80114 1388 04d2 0008 000004d21388c0a8011400051388
R c0a8fe01 ffffffff ffff 0035 05dc 05d40035fffffffffffffe01ffff
R 12345678 9abcdef0 abcd 1234 0009 00011234abcd9abcdef05678abcd
T 001804d2d431c0a80114010ad431 c0a8010a d431 0020
T 05d40035fffffffffffffe01ffff c0a8fe01 ffff 05dc
T fff8000000000000000012340050 c0a81234 0050 0000
T 0100aaaa5555deadbeef0007beef c0a80007 beef 0108
P 0 0123456789abcd5a ff 0 0
P 0 1122334455667788 ff 0 0
P 0 00000000deadbeef 0f 1 0
P 0 00000000000000c3 01 1 1
P 0 fedcba9876543217 ff 0 0
P 0 0000000000a5a5a5 07 1 0
P 1 0807060504030201 ff 0 0
P 1 000000000000100f 03 1 0
P 1 aaaaaaaaaaaaaaaa ff 0 0
P 1 5555555555555555 ff 0 1
P 1 0000000000000077 01 1 0

// File: vlog.f
+incdir+rtl
rtl/udp_pipe_pkg.sv
rtl/axis_skid_buffer.sv
rtl/udp_rx_hdr_pack.sv
rtl/udp_tx_hdr_unpack.sv
rtl/udp_rx_frame_tracker.sv
rtl/udp_pipe_top.sv
sim/tb_udp_pipe.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -f vlog.f \
		--top-module tb_udp_pipe --Mdir obj_dir -o tb_udp_pipe
	@out="$$(./obj_dir/tb_udp_pipe)"; \
		echo "$$out"; \
		echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
